// ==== logic/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath widths
`define RV_XLEN            32
`define RV_ALU_OP_WIDTH    5
`define RV_REG_ADDR_WIDTH  5

////////////////////////////////////////////////////////////////////////////
// Major opcodes, instruction bits 6 to 2
`define RV_OPC_OP          5'b01100
`define RV_OPC_OP_IMM      5'b00100
`define RV_OPC_LUI         5'b01101
`define RV_OPC_AUIPC       5'b00101
`define RV_OPC_BRANCH      5'b11000
`define RV_OPC_JAL         5'b11011
`define RV_OPC_JALR        5'b11001
`define RV_OPC_FENCE       5'b00011

////////////////////////////////////////////////////////////////////////////
// ALU operations, top bit set marks a comparison
`define RV_ALU_ADD         5'b00000
`define RV_ALU_SUB         5'b01000
`define RV_ALU_SLL         5'b00001
`define RV_ALU_SLTS        5'b00010
`define RV_ALU_SLTU        5'b00011
`define RV_ALU_XOR         5'b00100
`define RV_ALU_SRL         5'b00101
`define RV_ALU_SRA         5'b01101
`define RV_ALU_OR          5'b00110
`define RV_ALU_AND         5'b00111
`define RV_ALU_EQ          5'b11000
`define RV_ALU_NE          5'b11001
`define RV_ALU_LTS         5'b11100
`define RV_ALU_GES         5'b11101
`define RV_ALU_LTU         5'b11110
`define RV_ALU_GEU         5'b11111

// Operand selects
`define RV_OP_A_RS1        2'd0
`define RV_OP_A_PC         2'd1
`define RV_OP_A_ZERO       2'd2
`define RV_OP_B_RS2        2'd0
`define RV_OP_B_IMM        2'd1
`define RV_OP_B_FOUR       2'd2

`endif

// ==== logic/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

   // Raw fetched instruction
   typedef logic [31:0] instr_t;

   // Data word or program counter
   typedef logic [`RV_XLEN-1:0] xlen_t;

   // Register index
   typedef logic [`RV_REG_ADDR_WIDTH-1:0] reg_addr_t;

   // ALU operation code
   typedef logic [`RV_ALU_OP_WIDTH-1:0] alu_op_t;

   // Operand selects for the two ALU inputs
   typedef logic [1:0] op_a_sel_t;
   typedef logic [1:0] op_b_sel_t;

endpackage

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_decode
   import rv_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       instr_valid_i,
   input  instr_t     instr_i,
   input  xlen_t      pc_i,
   input  xlen_t      rs1_data_i,
   input  xlen_t      rs2_data_i,
   output logic       dec_valid_o,
   output alu_op_t    dec_alu_op_o,
   output op_a_sel_t  dec_op_a_sel_o,
   output op_b_sel_t  dec_op_b_sel_o,
   output xlen_t      dec_imm_o,
   output xlen_t      dec_pc_o,
   output xlen_t      dec_rs1_o,
   output xlen_t      dec_rs2_o,
   output reg_addr_t  dec_rd_o,
   output logic       dec_gpr_we_o,
   output logic       dec_branch_o,
   output logic       dec_jal_o,
   output logic       dec_jalr_o,
   output logic       dec_illegal_o
);

   logic [4:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       f7_zero;
   logic       f7_alt;
   xlen_t      imm_i, imm_u, imm_b, imm_j;

   alu_op_t    alu_op;
   op_a_sel_t  op_a_sel;
   op_b_sel_t  op_b_sel;
   xlen_t      imm;
   logic       gpr_we, branch, jal, jalr, illegal;

   assign opcode  = instr_i[6:2];
   assign funct3  = instr_i[14:12];
   assign funct7  = instr_i[31:25];
   assign f7_zero = (funct7 == 7'b0000000);
   assign f7_alt  = (funct7 == 7'b0100000);    // SUB and SRA

   // Sign-extended immediates
   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
   assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

   ////////////////////////////////////////////////////////////////////////////
   // Opcode, funct3 and funct7 decode
   always_comb begin
      alu_op   = `RV_ALU_ADD;
      op_a_sel = `RV_OP_A_RS1;
      op_b_sel = `RV_OP_B_RS2;
      imm      = imm_i;
      gpr_we   = 1'b0;
      branch   = 1'b0;
      jal      = 1'b0;
      jalr     = 1'b0;
      illegal  = 1'b0;

      if (instr_i[1:0] != 2'b11) begin
         illegal = 1'b1;                        // Compressed or reserved
      end else begin
         case (opcode)
            `RV_OPC_OP: begin
               gpr_we = 1'b1;
               case (funct3)
                  3'b000:  alu_op = f7_alt ? `RV_ALU_SUB : `RV_ALU_ADD;
                  3'b001:  alu_op = `RV_ALU_SLL;
                  3'b010:  alu_op = `RV_ALU_SLTS;
                  3'b011:  alu_op = `RV_ALU_SLTU;
                  3'b100:  alu_op = `RV_ALU_XOR;
                  3'b101:  alu_op = f7_alt ? `RV_ALU_SRA : `RV_ALU_SRL;
                  3'b110:  alu_op = `RV_ALU_OR;
                  default: alu_op = `RV_ALU_AND;
               endcase
               // Alternate funct7 only for SUB and SRA
               if (!f7_zero && !(f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                  illegal = 1'b1;
               end
            end
            `RV_OPC_OP_IMM: begin
               op_b_sel = `RV_OP_B_IMM;
               gpr_we   = 1'b1;
               case (funct3)
                  3'b000:  alu_op = `RV_ALU_ADD;
                  3'b001: begin
                     alu_op  = `RV_ALU_SLL;
                     illegal = !f7_zero;       // SLLI
                  end
                  3'b010:  alu_op = `RV_ALU_SLTS;
                  3'b011:  alu_op = `RV_ALU_SLTU;
                  3'b100:  alu_op = `RV_ALU_XOR;
                  3'b101: begin
                     alu_op  = f7_alt ? `RV_ALU_SRA : `RV_ALU_SRL;
                     illegal = !(f7_zero || f7_alt);
                  end
                  3'b110:  alu_op = `RV_ALU_OR;
                  default: alu_op = `RV_ALU_AND;
               endcase
            end
            `RV_OPC_LUI: begin
               op_a_sel = `RV_OP_A_ZERO;
               op_b_sel = `RV_OP_B_IMM;
               imm      = imm_u;
               gpr_we   = 1'b1;
            end
            `RV_OPC_AUIPC: begin
               op_a_sel = `RV_OP_A_PC;
               op_b_sel = `RV_OP_B_IMM;
               imm      = imm_u;
               gpr_we   = 1'b1;
            end
            `RV_OPC_BRANCH: begin
               imm    = imm_b;
               branch = 1'b1;
               case (funct3)
                  3'b000:  alu_op = `RV_ALU_EQ;
                  3'b001:  alu_op = `RV_ALU_NE;
                  3'b100:  alu_op = `RV_ALU_LTS;
                  3'b101:  alu_op = `RV_ALU_GES;
                  3'b110:  alu_op = `RV_ALU_LTU;
                  3'b111:  alu_op = `RV_ALU_GEU;
                  default: illegal = 1'b1;     // 010 and 011
               endcase
            end
            `RV_OPC_JAL: begin
               op_a_sel = `RV_OP_A_PC;         // Link is pc + 4
               op_b_sel = `RV_OP_B_FOUR;
               imm      = imm_j;
               gpr_we   = 1'b1;
               jal      = 1'b1;
            end
            `RV_OPC_JALR: begin
               op_a_sel = `RV_OP_A_PC;
               op_b_sel = `RV_OP_B_FOUR;
               gpr_we   = 1'b1;
               jalr     = 1'b1;
               illegal  = (funct3 != 3'b000);
            end
            `RV_OPC_FENCE: begin
               // No-operation, falls through to pc + 4
            end
            default: illegal = 1'b1;           // SYSTEM, loads, stores, others
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stage register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         dec_valid_o <= 1'b0;
      end else begin
         dec_valid_o <= instr_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (instr_valid_i) begin
         dec_alu_op_o   <= alu_op;
         dec_op_a_sel_o <= op_a_sel;
         dec_op_b_sel_o <= op_b_sel;
         dec_imm_o      <= imm;
         dec_pc_o       <= pc_i;
         dec_rs1_o      <= rs1_data_i;
         dec_rs2_o      <= rs2_data_i;
         dec_rd_o       <= instr_i[11:7];
         dec_gpr_we_o   <= gpr_we & ~illegal;  // Illegal kills all side effects
         dec_branch_o   <= branch & ~illegal;
         dec_jal_o      <= jal & ~illegal;
         dec_jalr_o     <= jalr & ~illegal;
         dec_illegal_o  <= illegal;
      end
   end

   // A live branch always carries a comparison code
   a_branch_compares : assert property (@(posedge clk_i) disable iff (reset_i)
      (dec_valid_o && dec_branch_o) |-> dec_alu_op_o[`RV_ALU_OP_WIDTH-1]);

endmodule

// ==== logic/rv_alu_execute.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_alu_execute
   import rv_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       dec_valid_i,
   input  alu_op_t    dec_alu_op_i,
   input  op_a_sel_t  dec_op_a_sel_i,
   input  op_b_sel_t  dec_op_b_sel_i,
   input  xlen_t      dec_imm_i,
   input  xlen_t      dec_pc_i,
   input  xlen_t      dec_rs1_i,
   input  xlen_t      dec_rs2_i,
   input  reg_addr_t  dec_rd_i,
   input  logic       dec_gpr_we_i,
   input  logic       dec_branch_i,
   input  logic       dec_jal_i,
   input  logic       dec_jalr_i,
   input  logic       dec_illegal_i,
   output logic       ex_valid_o,
   output xlen_t      ex_alu_result_o,
   output logic       ex_cmp_flag_o,
   output xlen_t      ex_pc_o,
   output xlen_t      ex_rs1_o,
   output xlen_t      ex_imm_o,
   output reg_addr_t  ex_rd_o,
   output logic       ex_gpr_we_o,
   output logic       ex_branch_o,
   output logic       ex_jal_o,
   output logic       ex_jalr_o,
   output logic       ex_illegal_o
);

   xlen_t op_a, op_b, result;
   logic  flag;

   always_comb begin
      case (dec_op_a_sel_i)
         `RV_OP_A_PC:   op_a = dec_pc_i;
         `RV_OP_A_ZERO: op_a = '0;             // LUI
         default:       op_a = dec_rs1_i;
      endcase
      case (dec_op_b_sel_i)
         `RV_OP_B_IMM:  op_b = dec_imm_i;
         `RV_OP_B_FOUR: op_b = xlen_t'(4);
         default:       op_b = dec_rs2_i;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // ALU
   always_comb begin
      flag = 1'b0;
      case (dec_alu_op_i)
         `RV_ALU_EQ:  flag = (op_a == op_b);
         `RV_ALU_NE:  flag = (op_a != op_b);
         `RV_ALU_LTS: flag = ($signed(op_a) <  $signed(op_b));
         `RV_ALU_GES: flag = ($signed(op_a) >= $signed(op_b));
         `RV_ALU_LTU: flag = (op_a <  op_b);
         `RV_ALU_GEU: flag = (op_a >= op_b);
         default:     flag = 1'b0;
      endcase

      case (dec_alu_op_i)
         `RV_ALU_ADD:  result = op_a + op_b;
         `RV_ALU_SUB:  result = op_a - op_b;
         `RV_ALU_SLL:  result = op_a << op_b[4:0];   // Shift amount is 5 bits
         `RV_ALU_SLTS: result = xlen_t'($signed(op_a) < $signed(op_b));
         `RV_ALU_SLTU: result = xlen_t'(op_a < op_b);
         `RV_ALU_XOR:  result = op_a ^ op_b;
         `RV_ALU_SRL:  result = op_a >> op_b[4:0];
         `RV_ALU_SRA:  result = xlen_t'($signed(op_a) >>> op_b[4:0]);
         `RV_ALU_OR:   result = op_a | op_b;
         `RV_ALU_AND:  result = op_a & op_b;
         default:      result = xlen_t'(flag);       // Comparisons
      endcase
   end

   // Stage register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ex_valid_o <= 1'b0;
      end else begin
         ex_valid_o <= dec_valid_i;
      end
   end

   always_ff @(posedge clk_i) begin
      ex_alu_result_o <= result;
      ex_cmp_flag_o   <= flag;
      ex_pc_o         <= dec_pc_i;
      ex_rs1_o        <= dec_rs1_i;                  // JALR base
      ex_imm_o        <= dec_imm_i;
      ex_rd_o         <= dec_rd_i;
      ex_gpr_we_o     <= dec_gpr_we_i;
      ex_branch_o     <= dec_branch_i;
      ex_jal_o        <= dec_jal_i;
      ex_jalr_o       <= dec_jalr_i;
      ex_illegal_o    <= dec_illegal_i;
   end

   a_known_alu_op : assert property (@(posedge clk_i) disable iff (reset_i)
      dec_valid_i |-> dec_alu_op_i inside {
         `RV_ALU_ADD, `RV_ALU_SUB, `RV_ALU_SLL, `RV_ALU_SLTS, `RV_ALU_SLTU,
         `RV_ALU_XOR, `RV_ALU_SRL, `RV_ALU_SRA, `RV_ALU_OR, `RV_ALU_AND,
         `RV_ALU_EQ, `RV_ALU_NE, `RV_ALU_LTS, `RV_ALU_GES, `RV_ALU_LTU,
         `RV_ALU_GEU});

endmodule

// ==== logic/rv_result_select.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_result_select
   import rv_pkg::*;
(
   input  logic       ex_valid_i,
   input  xlen_t      ex_alu_result_i,
   input  logic       ex_cmp_flag_i,
   input  xlen_t      ex_pc_i,
   input  xlen_t      ex_rs1_i,
   input  xlen_t      ex_imm_i,
   input  reg_addr_t  ex_rd_i,
   input  logic       ex_gpr_we_i,
   input  logic       ex_branch_i,
   input  logic       ex_jal_i,
   input  logic       ex_jalr_i,
   output logic       result_valid_o,
   output logic       gpr_we_o,
   output reg_addr_t  rd_addr_o,
   output xlen_t      rd_data_o,
   output xlen_t      next_pc_o
);

   xlen_t target;

   assign target = (ex_jalr_i ? ex_rs1_i : ex_pc_i) + ex_imm_i;   // JALR is rs1 relative

   always_comb begin
      if ((ex_branch_i && ex_cmp_flag_i) || ex_jal_i) begin
         next_pc_o = target;
      end else if (ex_jalr_i) begin
         next_pc_o = {target[`RV_XLEN-1:1], 1'b0};
      end else begin
         next_pc_o = ex_pc_i + xlen_t'(4);                         // Sequential
      end
   end

   // Write-back
   assign result_valid_o = ex_valid_i;
   assign gpr_we_o       = ex_valid_i & ex_gpr_we_i;
   assign rd_addr_o      = ex_rd_i;
   assign rd_data_o      = ex_alu_result_i;

   // Catches a misaligned pc or a branch offset with bit 0 set upstream
   always_comb begin
      if (ex_valid_i) begin
         a_pc_even : assert (!next_pc_o[0]);
      end
   end

endmodule

// ==== logic/rv_exec_core.sv ====
`timescale 1ns/1ns

module rv_exec_core
   import rv_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       instr_valid_i,
   input  instr_t     instr_i,
   input  xlen_t      pc_i,
   input  xlen_t      rs1_data_i,
   input  xlen_t      rs2_data_i,
   output logic       result_valid_o,
   output logic       gpr_we_o,
   output reg_addr_t  rd_addr_o,
   output xlen_t      rd_data_o,
   output xlen_t      next_pc_o,
   output logic       illegal_instr_o
);

   // Decode to execute
   logic       dec_valid, dec_gpr_we, dec_branch, dec_jal, dec_jalr, dec_illegal;
   alu_op_t    dec_alu_op;
   op_a_sel_t  dec_op_a_sel;
   op_b_sel_t  dec_op_b_sel;
   xlen_t      dec_imm, dec_pc, dec_rs1, dec_rs2;
   reg_addr_t  dec_rd;

   // Execute to result
   logic       ex_valid, ex_cmp_flag, ex_gpr_we, ex_branch, ex_jal, ex_jalr, ex_illegal;
   xlen_t      ex_alu_result, ex_pc, ex_rs1, ex_imm;
   reg_addr_t  ex_rd;

   rv_decode u_decode (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .instr_valid_i  (instr_valid_i),
      .instr_i        (instr_i),
      .pc_i           (pc_i),
      .rs1_data_i     (rs1_data_i),
      .rs2_data_i     (rs2_data_i),
      .dec_valid_o    (dec_valid),
      .dec_alu_op_o   (dec_alu_op),
      .dec_op_a_sel_o (dec_op_a_sel),
      .dec_op_b_sel_o (dec_op_b_sel),
      .dec_imm_o      (dec_imm),
      .dec_pc_o       (dec_pc),
      .dec_rs1_o      (dec_rs1),
      .dec_rs2_o      (dec_rs2),
      .dec_rd_o       (dec_rd),
      .dec_gpr_we_o   (dec_gpr_we),
      .dec_branch_o   (dec_branch),
      .dec_jal_o      (dec_jal),
      .dec_jalr_o     (dec_jalr),
      .dec_illegal_o  (dec_illegal)
   );

   rv_alu_execute u_alu_execute (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .dec_valid_i     (dec_valid),
      .dec_alu_op_i    (dec_alu_op),
      .dec_op_a_sel_i  (dec_op_a_sel),
      .dec_op_b_sel_i  (dec_op_b_sel),
      .dec_imm_i       (dec_imm),
      .dec_pc_i        (dec_pc),
      .dec_rs1_i       (dec_rs1),
      .dec_rs2_i       (dec_rs2),
      .dec_rd_i        (dec_rd),
      .dec_gpr_we_i    (dec_gpr_we),
      .dec_branch_i    (dec_branch),
      .dec_jal_i       (dec_jal),
      .dec_jalr_i      (dec_jalr),
      .dec_illegal_i   (dec_illegal),
      .ex_valid_o      (ex_valid),
      .ex_alu_result_o (ex_alu_result),
      .ex_cmp_flag_o   (ex_cmp_flag),
      .ex_pc_o         (ex_pc),
      .ex_rs1_o        (ex_rs1),
      .ex_imm_o        (ex_imm),
      .ex_rd_o         (ex_rd),
      .ex_gpr_we_o     (ex_gpr_we),
      .ex_branch_o     (ex_branch),
      .ex_jal_o        (ex_jal),
      .ex_jalr_o       (ex_jalr),
      .ex_illegal_o    (ex_illegal)
   );

   rv_result_select u_result_select (
      .ex_valid_i      (ex_valid),
      .ex_alu_result_i (ex_alu_result),
      .ex_cmp_flag_i   (ex_cmp_flag),
      .ex_pc_i         (ex_pc),
      .ex_rs1_i        (ex_rs1),
      .ex_imm_i        (ex_imm),
      .ex_rd_i         (ex_rd),
      .ex_gpr_we_i     (ex_gpr_we),
      .ex_branch_i     (ex_branch),
      .ex_jal_i        (ex_jal),
      .ex_jalr_i       (ex_jalr),
      .result_valid_o  (result_valid_o),
      .gpr_we_o        (gpr_we_o),
      .rd_addr_o       (rd_addr_o),
      .rd_data_o       (rd_data_o),
      .next_pc_o       (next_pc_o)
   );

   assign illegal_instr_o = ex_valid & ex_illegal;   // Only for a live instruction

endmodule

// ==== dv/rv_exec_core_tb.sv ====
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_exec_core_tb
   import rv_pkg::*;
();

   // Expected response of one instruction
   typedef struct packed {
      logic        we;
      logic        illegal;
      logic        check_data;
      reg_addr_t   rd;
      xlen_t       data;
      xlen_t       next_pc;
      logic [31:0] due;
   } expect_t;

   logic       clk_i;
   logic       reset_i;
   logic       instr_valid_i;
   instr_t     instr_i;
   xlen_t      pc_i, rs1_data_i, rs2_data_i;
   logic       result_valid_o, gpr_we_o, illegal_instr_o;
   reg_addr_t  rd_addr_o;
   xlen_t      rd_data_o, next_pc_o;

   integer      seed = 32'h221;
   logic [31:0] cycle = 0;            // Rising edges seen so far
   expect_t     pending[$];

   rv_exec_core dut (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .instr_valid_i   (instr_valid_i),
      .instr_i         (instr_i),
      .pc_i            (pc_i),
      .rs1_data_i      (rs1_data_i),
      .rs2_data_i      (rs2_data_i),
      .result_valid_o  (result_valid_o),
      .gpr_we_o        (gpr_we_o),
      .rd_addr_o       (rd_addr_o),
      .rd_data_o       (rd_data_o),
      .next_pc_o       (next_pc_o),
      .illegal_instr_o (illegal_instr_o)
   );

   initial clk_i = 1'b0;
   always #10 clk_i = ~clk_i;

   function automatic xlen_t next_random();
      return $random(seed);
   endfunction

   function automatic instr_t build_instr(input logic [6:0] f7, input logic [4:0] r2,
                                          input logic [4:0] r1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] opc);
      return {f7, r2, r1, f3, rd, opc, 2'b11};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reference model, straight from the ISA rules
   function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                       input xlen_t x, input xlen_t y);
      case (f3)
         3'd0:    return alt ? x - y : x + y;
         3'd1:    return x << y[4:0];
         3'd2:    return {31'b0, ($signed(x) < $signed(y))};
         3'd3:    return {31'b0, (x < y)};
         3'd4:    return x ^ y;
         3'd5: begin
            if (alt) begin
               return $signed(x) >>> y[4:0];   // SRA keeps the sign
            end
            return x >> y[4:0];
         end
         3'd6:    return x | y;
         default: return x & y;
      endcase
   endfunction

   function automatic expect_t predict_result(input instr_t ins, input xlen_t pc,
                                              input xlen_t a, input xlen_t b);
      expect_t    e;
      logic [2:0] f3;
      logic [6:0] f7;
      xlen_t      imm_i, imm_u, imm_b, imm_j;
      logic       bad, taken;
      f3    = ins[14:12];
      f7    = ins[31:25];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_u = {ins[31:12], 12'b0};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      e.we         = 1'b0;
      e.illegal    = 1'b0;
      e.check_data = 1'b1;
      e.rd         = ins[11:7];
      e.data       = '0;
      e.next_pc    = pc + 32'd4;
      e.due        = '0;
      bad          = 1'b0;
      taken        = 1'b0;
      if (ins[1:0] != 2'b11) begin
         bad = 1'b1;
      end else begin
         case (ins[6:2])
            `RV_OPC_OP: begin
               bad    = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
               e.data = alu_model(f3, f7[5], a, b);
               e.we   = 1'b1;
            end
            `RV_OPC_OP_IMM: begin
               if (f3 == 3'd1) bad = (f7 != 7'h00);
               if (f3 == 3'd5) bad = !(f7 == 7'h00 || f7 == 7'h20);
               e.data = alu_model(f3, (f3 == 3'd5) && f7[5], a, imm_i);
               e.we   = 1'b1;
            end
            `RV_OPC_LUI: begin
               e.data = imm_u;
               e.we   = 1'b1;
            end
            `RV_OPC_AUIPC: begin
               e.data = pc + imm_u;
               e.we   = 1'b1;
            end
            `RV_OPC_BRANCH: begin
               case (f3)
                  3'd0:    taken = (a == b);
                  3'd1:    taken = (a != b);
                  3'd4:    taken = ($signed(a) < $signed(b));
                  3'd5:    taken = ($signed(a) >= $signed(b));
                  3'd6:    taken = (a < b);
                  3'd7:    taken = (a >= b);
                  default: bad = 1'b1;
               endcase
               e.data = {31'b0, taken};       // Flag only, never written back
               if (taken) e.next_pc = pc + imm_b;
            end
            `RV_OPC_JAL: begin
               e.data    = pc + 32'd4;
               e.we      = 1'b1;
               e.next_pc = pc + imm_j;
            end
            `RV_OPC_JALR: begin
               bad       = (f3 != 3'd0);
               e.data    = pc + 32'd4;
               e.we      = 1'b1;
               e.next_pc = (a + imm_i) & ~32'd1;
            end
            `RV_OPC_FENCE: e.check_data = 1'b0;
            default:       bad = 1'b1;
         endcase
      end
      if (bad) begin
         e.we         = 1'b0;
         e.illegal    = 1'b1;
         e.check_data = 1'b0;
         e.next_pc    = pc + 32'd4;
      end
      return e;
   endfunction

   task automatic compare_value(input string name, input xlen_t actual, input xlen_t expected);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s got %h, expected %h", $time, name, actual, expected);
         $display("Test failures found");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Drive one instruction on the falling edge and queue its prediction
   task automatic issue(input instr_t ins, input xlen_t a, input xlen_t b);
      expect_t e;
      xlen_t   pc;
      @(negedge clk_i);
      pc            = next_random() & 32'hffff_fffc;
      instr_valid_i = 1'b1;
      instr_i       = ins;
      pc_i          = pc;
      rs1_data_i    = a;
      rs2_data_i    = b;
      e             = predict_result(ins, pc, a, b);
      e.due         = cycle + 32'd2;
      pending.push_back(e);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk_i);
         instr_valid_i = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Output comparison, just after each rising edge
   always @(posedge clk_i) begin : compare_outputs
      expect_t head;
      #1;
      cycle = cycle + 32'd1;
      if (pending.size() != 0 && pending[0].due == cycle) begin
         head = pending.pop_front();
         compare_value("result_valid_o", xlen_t'(result_valid_o), 32'd1);
         compare_value("gpr_we_o", xlen_t'(gpr_we_o), xlen_t'(head.we));
         compare_value("illegal_instr_o", xlen_t'(illegal_instr_o), xlen_t'(head.illegal));
         compare_value("next_pc_o", next_pc_o, head.next_pc);
         if (head.check_data) compare_value("rd_data_o", rd_data_o, head.data);
         if (head.we) compare_value("rd_addr_o", xlen_t'(rd_addr_o), xlen_t'(head.rd));
      end else begin
         compare_value("result_valid_o", xlen_t'(result_valid_o), 32'd0);
         compare_value("gpr_we_o", xlen_t'(gpr_we_o), 32'd0);
         compare_value("illegal_instr_o", xlen_t'(illegal_instr_o), 32'd0);
      end
   end

   initial begin : stimulus
      int          i, j, k, wait_count;
      xlen_t       r, a, b, gap;
      logic [2:0]  f3;
      logic [6:0]  f7;
      reset_i       = 1'b1;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      pc_i          = '0;
      rs1_data_i    = '0;
      rs2_data_i    = '0;

      // 1: reset, result_valid_o must stay low
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      idle_cycles(3);

      // 2: register and immediate ALU forms, every funct3 with and without alt
      for (i = 0; i < 32; i++) begin
         r  = next_random();
         f3 = i[2:0];
         f7 = (i[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
         issue(build_instr(f7, r[24:20], r[19:15], f3, r[11:7], `RV_OPC_OP),
               next_random(), next_random());
         if (f3 != 3'd1 && f3 != 3'd5) f7 = r[31:25];   // Plain immediate bits
         issue(build_instr(f7, r[24:20], r[19:15], f3, r[11:7], `RV_OPC_OP_IMM),
               next_random(), next_random());
      end
      idle_cycles(2);

      // 3: LUI, AUIPC and FENCE
      for (i = 0; i < 6; i++) begin
         r = next_random();
         issue({r[31:7], `RV_OPC_LUI, 2'b11}, next_random(), next_random());
         issue({r[31:7], `RV_OPC_AUIPC, 2'b11}, next_random(), next_random());
         issue({r[31:7], `RV_OPC_FENCE, 2'b11}, next_random(), next_random());
      end
      idle_cycles(2);

      // 4: branches with equal, signed-less and unsigned-less pairs
      for (j = 0; j < 8; j++) begin
         if (j == 2 || j == 3) continue;
         for (k = 0; k < 3; k++) begin
            r = next_random();
            a = next_random();
            b = next_random();
            if (k == 0) b = a;
            if (k == 1) begin
               a = a | 32'h8000_0000;              // Negative against positive
               b = b & 32'h7fff_ffff;
            end
            if (k == 2) begin
               a = a & 32'h7fff_ffff;
               b = b | 32'h8000_0000;
            end
            f3 = j[2:0];
            issue(build_instr(r[31:25], r[24:20], r[19:15], f3, r[11:7], `RV_OPC_BRANCH), a, b);
            issue(build_instr(r[31:25], r[24:20], r[19:15], f3, r[11:7], `RV_OPC_BRANCH), b, a);
         end
      end
      idle_cycles(2);

      // 5: JAL and JALR, rs1 may be odd
      for (i = 0; i < 8; i++) begin
         r = next_random();
         issue({r[31:7], `RV_OPC_JAL, 2'b11}, next_random(), next_random());
         issue(build_instr(r[31:25], r[24:20], r[19:15], 3'd0, r[11:7], `RV_OPC_JALR),
               next_random(), next_random());
      end
      idle_cycles(2);

      ////////////////////////////////////////////////////////////////////////////
      // 6: illegal encodings mixed with legal ones, random gaps
      for (i = 0; i < 42; i++) begin
         r = next_random();
         case (i % 7)
            0: issue({r[31:2], r[0], 1'b0}, next_random(), next_random());
            1: issue(build_instr(7'h01, r[24:20], r[19:15], r[14:12], r[11:7], `RV_OPC_OP),
                     next_random(), next_random());
            2: issue({r[31:7], 5'b11100, 2'b11}, next_random(), next_random());  // SYSTEM
            3: issue(build_instr(r[31:25], r[24:20], r[19:15], {2'b01, r[12]}, r[11:7],
                     `RV_OPC_BRANCH), next_random(), next_random());
            4: issue(build_instr(r[31:25], r[24:20], r[19:15], {r[14:13], 1'b1}, r[11:7],
                     `RV_OPC_JALR), next_random(), next_random());
            5: issue(build_instr({2'b01, r[29:25]}, r[24:20], r[19:15], 3'd1, r[11:7],
                     `RV_OPC_OP_IMM), next_random(), next_random());                 // Bad SLLI
            default: issue(build_instr(7'h00, r[24:20], r[19:15], r[14:12], r[11:7],
                     `RV_OPC_OP), next_random(), next_random());
         endcase
         gap = next_random();
         if (gap[0]) idle_cycles(int'(gap[2:1]));
      end
      idle_cycles(1);

      // Drain whatever is still in flight
      wait_count = 0;
      while (pending.size() != 0 && wait_count < 20) begin
         @(posedge clk_i);
         wait_count++;
      end
      if (pending.size() != 0) begin
         $display("Timeout with %0d results still expected", pending.size());
         $display("Test failures found");
         $fatal(1, "Pipeline did not drain");
      end
      @(posedge clk_i);

      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_alu_execute.sv
logic/rv_result_select.sv
logic/rv_exec_core.sv
dv/rv_exec_core_tb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = rv_exec_core_tb
FLIST = flist.f

.PHONY: sim clean

# Passes only when the pass message shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
